/* include/aib_consts.svh */
// Widths and config register addresses of the AIB channel, included by RTL and testbench
`ifndef AIB_CONSTS_SVH
`define AIB_CONSTS_SVH

// --------------------------------------------------
// Data path widths
`define AIB_WORD_W      40          // Local word
`define AIB_BEAT_W      20          // Pad beat, half a word
`define AIB_CNT_W       16          // Word and error counters

// --------------------------------------------------
// Avalon-MM config bus
`define AIB_CFG_ADDR_W  17
`define AIB_CFG_DATA_W  32

// Register map
`define AIB_REG_CTRL    17'h00000   // Bit 0 tx enable, bit 1 rx enable
`define AIB_REG_WORDS   17'h00004   // Word count, any write clears counters
`define AIB_REG_ERRS    17'h00008   // Framing error count, read only

`endif

/* logic/aib_pkg.sv */
// Shared types of the AIB channel, imported by the RTL modules and the testbench
`default_nettype none

`include "aib_consts.svh"

package aib_pkg;

    // --------------------------------------------------
    // Data and bus widths with a meaning
    typedef logic [`AIB_WORD_W-1:0]     aib_word_t;      // Local word
    typedef logic [`AIB_BEAT_W-1:0]     aib_beat_t;      // One pad beat
    typedef logic [`AIB_CFG_ADDR_W-1:0] aib_cfg_addr_t;
    typedef logic [`AIB_CFG_DATA_W-1:0] aib_cfg_data_t;
    typedef logic [`AIB_CNT_W-1:0]      aib_cnt_t;       // Saturating counter

    // --------------------------------------------------
    // FSM states
    typedef enum logic {
        TX_IDLE,                    // Ready for a new word
        TX_HIGH                     // High half still to send
    } tx_state_e;

    typedef enum logic {
        RX_LOW,                     // Waiting for a marked low beat
        RX_HIGH                     // Low half held, expecting high beat
    } rx_state_e;

endpackage

`default_nettype wire

/* logic/aib_rx_ctrl_if.sv */
// Control and status link between the config block and the receive adapter
`default_nettype none

interface aib_rx_ctrl_if
    import aib_pkg::*;
();

    logic     rx_en;                // Receive direction enabled
    logic     cnt_clr;              // One cycle clear of both counters
    aib_cnt_t word_cnt;             // Completed words
    aib_cnt_t err_cnt;              // Framing errors

    // Config side sets control, reads status
    modport cfg (
        output rx_en, cnt_clr,
        input  word_cnt, err_cnt
    );

    // Receive adapter side
    modport rx (
        input  rx_en, cnt_clr,
        output word_cnt, err_cnt
    );

endinterface

`default_nettype wire

/* logic/aib_cfg_avmm.sv */
// Avalon-MM register block of the channel, holds the enables and reads back the rx counters
`default_nettype none

`include "aib_consts.svh"

module aib_cfg_avmm
    import aib_pkg::*;
(
    input  wire logic          i_tx_pma_clk,
    input  wire logic          i_rst_n,

    // Avalon-MM slave
    input  wire aib_cfg_addr_t i_cfg_avmm_addr,
    input  wire logic          i_cfg_avmm_read,
    input  wire logic          i_cfg_avmm_write,
    input  wire aib_cfg_data_t i_cfg_avmm_wdata,
    output aib_cfg_data_t      o_cfg_avmm_rdata,
    output logic               o_cfg_avmm_rdatavld,

    // To the adapters
    output logic               o_tx_en,
    aib_rx_ctrl_if.cfg         rx_ctrl
);

    logic [1:0]    ctrl_q;          // {rx_en, tx_en}
    logic          wr_ctrl;
    logic          wr_words;
    aib_cfg_data_t rd_mux;

    // --------------------------------------------------
    // Write decode
    assign wr_ctrl  = i_cfg_avmm_write && (i_cfg_avmm_addr == `AIB_REG_CTRL);
    assign wr_words = i_cfg_avmm_write && (i_cfg_avmm_addr == `AIB_REG_WORDS);

    always_ff @(posedge i_tx_pma_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctrl_q <= 2'b00;                            // Both directions off
        end else if (wr_ctrl) begin
            ctrl_q <= i_cfg_avmm_wdata[1:0];
        end
    end

    assign o_tx_en       = ctrl_q[0];
    assign rx_ctrl.rx_en = ctrl_q[1];

    // Counters clear at the accept edge itself, so the zero shows next cycle
    assign rx_ctrl.cnt_clr = wr_words;

    // --------------------------------------------------
    // Read path
    always_comb begin
        case (i_cfg_avmm_addr)
            `AIB_REG_CTRL: begin
                rd_mux = {{(`AIB_CFG_DATA_W-2){1'b0}}, ctrl_q};
            end
            `AIB_REG_WORDS: begin
                rd_mux = {{(`AIB_CFG_DATA_W-`AIB_CNT_W){1'b0}}, rx_ctrl.word_cnt};
            end
            `AIB_REG_ERRS: begin
                rd_mux = {{(`AIB_CFG_DATA_W-`AIB_CNT_W){1'b0}}, rx_ctrl.err_cnt};
            end
            default: begin
                rd_mux = '0;                            // Unmapped
            end
        endcase
    end

    always_ff @(posedge i_tx_pma_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cfg_avmm_rdatavld <= 1'b0;
        end else begin
            o_cfg_avmm_rdatavld <= i_cfg_avmm_read;     // One cycle pulse per read
        end
    end

    always_ff @(posedge i_tx_pma_clk) begin
        if (i_cfg_avmm_read) begin
            o_cfg_avmm_rdata <= rd_mux;
        end
    end

    // --------------------------------------------------
    // Bus protocol
    a_no_rd_wr_overlap: assert property (
        @(posedge i_tx_pma_clk) disable iff (!i_rst_n)
        !(i_cfg_avmm_read && i_cfg_avmm_write)
    ) else $error("cfg read and write asserted together");

endmodule

`default_nettype wire

/* logic/aib_tx_adapt.sv */
// Transmit adapter, splits each accepted word into a marked low beat and a high beat on the pads
`default_nettype none

`include "aib_consts.svh"

module aib_tx_adapt
    import aib_pkg::*;
(
    input  wire logic      i_tx_pma_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_tx_en,

    // Local word source
    input  wire aib_word_t i_tx_data,
    input  wire logic      i_tx_valid,
    output logic           o_tx_ready,

    // Pads
    output aib_beat_t      o_iopad_tx,
    output logic           o_iopad_tx_vld,
    output logic           o_iopad_tx_mark
);

    tx_state_e state_q;
    aib_beat_t hi_half_q;           // High half waiting for its beat
    logic      accept;

    // --------------------------------------------------
    // Handshake
    assign o_tx_ready = (state_q == TX_IDLE) && i_tx_en;
    assign accept     = i_tx_valid && o_tx_ready;

    // --------------------------------------------------
    // FSM and pad qualifiers
    always_ff @(posedge i_tx_pma_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q         <= TX_IDLE;
            o_iopad_tx_vld  <= 1'b0;
            o_iopad_tx_mark <= 1'b0;
        end else begin
            unique case (state_q)
                TX_IDLE: begin
                    o_iopad_tx_vld  <= accept;          // Low beat goes out
                    o_iopad_tx_mark <= accept;          // Marks start of word
                    if (accept) begin
                        state_q <= TX_HIGH;
                    end
                end
                TX_HIGH: begin
                    // Finishes even if tx_en dropped meanwhile
                    o_iopad_tx_vld  <= 1'b1;
                    o_iopad_tx_mark <= 1'b0;
                    state_q         <= TX_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Beat data
    always_ff @(posedge i_tx_pma_clk) begin
        if (accept) begin
            o_iopad_tx <= i_tx_data[`AIB_BEAT_W-1:0];
            hi_half_q  <= i_tx_data[`AIB_WORD_W-1:`AIB_BEAT_W];
        end else if (state_q == TX_HIGH) begin
            o_iopad_tx <= hi_half_q;
        end
    end

    // A marked beat carries data and is always followed by its unmarked high beat
    a_mark_then_high: assert property (
        @(posedge i_tx_pma_clk) disable iff (!i_rst_n)
        o_iopad_tx_mark |-> o_iopad_tx_vld ##1 (o_iopad_tx_vld && !o_iopad_tx_mark)
    ) else $error("tx mark without valid or without following high beat");

endmodule

`default_nettype wire

/* logic/aib_rx_adapt.sv */
// Receive adapter, samples the pads, rebuilds words from beat pairs and counts words and errors
`default_nettype none

`include "aib_consts.svh"

module aib_rx_adapt
    import aib_pkg::*;
(
    input  wire logic      i_tx_pma_clk,
    input  wire logic      i_rst_n,

    // Pads
    input  wire aib_beat_t i_iopad_rx,
    input  wire logic      i_iopad_rx_vld,
    input  wire logic      i_iopad_rx_mark,

    // Local word sink, no back-pressure
    output aib_word_t      o_rx_data,
    output logic           o_rx_valid,

    aib_rx_ctrl_if.rx      rx_ctrl
);

    aib_beat_t beat_q;              // Sampled pad beat
    logic      vld_q;
    logic      mark_q;
    aib_beat_t lo_half_q;           // Low half of word in progress
    rx_state_e state_q;
    aib_cnt_t  word_cnt_q;
    aib_cnt_t  err_cnt_q;

    logic      beat_ok;
    logic      word_done;
    logic      frame_err;

    // --------------------------------------------------
    // Pad sampling
    always_ff @(posedge i_tx_pma_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q  <= 1'b0;
            mark_q <= 1'b0;
        end else begin
            vld_q  <= i_iopad_rx_vld;
            mark_q <= i_iopad_rx_mark;
        end
    end

    always_ff @(posedge i_tx_pma_clk) begin
        beat_q <= i_iopad_rx;
    end

    // --------------------------------------------------
    // Framing
    assign beat_ok   = rx_ctrl.rx_en && vld_q;
    assign word_done = beat_ok && (state_q == RX_HIGH) && !mark_q;
    assign frame_err = beat_ok && (((state_q == RX_LOW) && !mark_q)
                                || ((state_q == RX_HIGH) && mark_q));

    always_ff @(posedge i_tx_pma_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= RX_LOW;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= word_done;
            if (!rx_ctrl.rx_en) begin
                state_q <= RX_LOW;                      // Drop any half word
            end else if (beat_ok && mark_q) begin
                state_q <= RX_HIGH;                     // Marked beat starts a word
            end else if (word_done) begin
                state_q <= RX_LOW;
            end
        end
    end

    always_ff @(posedge i_tx_pma_clk) begin
        if (beat_ok && mark_q) begin
            lo_half_q <= beat_q;                        // Also resyncs on a stray mark
        end
        if (word_done) begin
            o_rx_data <= {beat_q, lo_half_q};
        end
    end

    // --------------------------------------------------
    // Saturating counters
    always_ff @(posedge i_tx_pma_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            word_cnt_q <= '0;
            err_cnt_q  <= '0;
        end else if (rx_ctrl.cnt_clr) begin
            word_cnt_q <= '0;
            err_cnt_q  <= '0;
        end else begin
            if (word_done && (word_cnt_q != '1)) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
            if (frame_err && (err_cnt_q != '1)) begin
                err_cnt_q <= err_cnt_q + 1'b1;
            end
        end
    end

    assign rx_ctrl.word_cnt = word_cnt_q;
    assign rx_ctrl.err_cnt  = err_cnt_q;

    // A word needs two beats, so valid can never repeat back to back
    a_rx_valid_pulse: assert property (
        @(posedge i_tx_pma_clk) disable iff (!i_rst_n)
        o_rx_valid |=> !o_rx_valid
    ) else $error("rx valid held for two cycles");

endmodule

`default_nettype wire

/* logic/aib_chan_top.sv */
// Top level of one AIB channel, joins config, transmit and receive adapters with plain ports
`default_nettype none

module aib_chan_top
    import aib_pkg::*;
(
    input  wire logic          i_tx_pma_clk,
    input  wire logic          i_rst_n,

    // --------------------------------------------------
    // Config bus
    input  wire aib_cfg_addr_t i_cfg_avmm_addr,
    input  wire logic          i_cfg_avmm_read,
    input  wire logic          i_cfg_avmm_write,
    input  wire aib_cfg_data_t i_cfg_avmm_wdata,
    output aib_cfg_data_t      o_cfg_avmm_rdata,
    output logic               o_cfg_avmm_rdatavld,

    // --------------------------------------------------
    // Local transmit side
    input  wire aib_word_t     i_tx_data,
    input  wire logic          i_tx_valid,
    output logic               o_tx_ready,

    // Local receive side
    output aib_word_t          o_rx_data,
    output logic               o_rx_valid,

    // --------------------------------------------------
    // Pads
    output aib_beat_t          o_iopad_tx,
    output logic               o_iopad_tx_vld,
    output logic               o_iopad_tx_mark,
    input  wire aib_beat_t     i_iopad_rx,
    input  wire logic          i_iopad_rx_vld,
    input  wire logic          i_iopad_rx_mark
);

    logic tx_en;                    // Transmit enable from control register

    aib_rx_ctrl_if u_rx_ctrl_if ();

    aib_cfg_avmm u_cfg_avmm (
        .i_tx_pma_clk        (i_tx_pma_clk),
        .i_rst_n             (i_rst_n),
        .i_cfg_avmm_addr     (i_cfg_avmm_addr),
        .i_cfg_avmm_read     (i_cfg_avmm_read),
        .i_cfg_avmm_write    (i_cfg_avmm_write),
        .i_cfg_avmm_wdata    (i_cfg_avmm_wdata),
        .o_cfg_avmm_rdata    (o_cfg_avmm_rdata),
        .o_cfg_avmm_rdatavld (o_cfg_avmm_rdatavld),
        .o_tx_en             (tx_en),
        .rx_ctrl             (u_rx_ctrl_if.cfg)
    );

    aib_tx_adapt u_tx_adapt (
        .i_tx_pma_clk    (i_tx_pma_clk),
        .i_rst_n         (i_rst_n),
        .i_tx_en         (tx_en),
        .i_tx_data       (i_tx_data),
        .i_tx_valid      (i_tx_valid),
        .o_tx_ready      (o_tx_ready),
        .o_iopad_tx      (o_iopad_tx),
        .o_iopad_tx_vld  (o_iopad_tx_vld),
        .o_iopad_tx_mark (o_iopad_tx_mark)
    );

    // Receive only sees the far die through its pads
    aib_rx_adapt u_rx_adapt (
        .i_tx_pma_clk    (i_tx_pma_clk),
        .i_rst_n         (i_rst_n),
        .i_iopad_rx      (i_iopad_rx),
        .i_iopad_rx_vld  (i_iopad_rx_vld),
        .i_iopad_rx_mark (i_iopad_rx_mark),
        .o_rx_data       (o_rx_data),
        .o_rx_valid      (o_rx_valid),
        .rx_ctrl         (u_rx_ctrl_if.rx)
    );

endmodule

`default_nettype wire

/* tb/aib_chan_checker.sv */
// Testbench checker, models the channel from its ports and pad wires and reports mismatches
`default_nettype none

`include "aib_consts.svh"

module aib_chan_checker
    import aib_pkg::*;
(
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire aib_cfg_addr_t i_addr,
    input  wire logic          i_read,
    input  wire logic          i_write,
    input  wire aib_cfg_data_t i_wdata,
    input  wire aib_cfg_data_t i_rdata,
    input  wire logic          i_rdatavld,
    input  wire aib_word_t     i_tx_data,
    input  wire logic          i_tx_valid,
    input  wire logic          i_tx_ready,
    input  wire aib_word_t     i_rx_data,
    input  wire logic          i_rx_valid,
    input  wire aib_beat_t     i_pad_beat,
    input  wire logic          i_pad_vld,
    input  wire logic          i_pad_tx_mark,
    input  wire logic          i_pad_rx_mark,
    output int                 o_val_errs,
    output int                 o_proto_errs
);

    string         test_name = "none";
    logic [1:0]    ctrl = 2'b00;            // Model of control register
    int            words = 0;
    int            errs = 0;
    logic          hi_state = 1'b0;         // 1 means low half held
    aib_beat_t     lo;
    logic          p_vld = 1'b0;            // Pad beat registered by the receiver
    logic          p_mark = 1'b0;
    logic          p_txmark = 1'b0;
    aib_beat_t     p_beat;
    aib_word_t     acc_q[$];                // Accepted words in order
    int            acc_cyc[$];
    aib_word_t     cur_word;
    int            cur_cyc = 0;
    logic          exp_vld = 1'b0;
    aib_word_t     exp_data;
    logic          rd_pend = 1'b0;
    aib_cfg_data_t rd_exp;
    logic          prev_acc = 1'b0;
    int            cyc = 0;
    int            r;

    initial begin
        o_val_errs   = 0;
        o_proto_errs = 0;
    end

    // Framing rule for a valid beat with rx enabled
    // Bit 0 word done, bit 1 error, bit 2 next state
    function automatic int frame_beat(input logic st, input logic mark);
        if (!st) begin
            return mark ? 4 : 2;
        end
        return mark ? 6 : 1;
    endfunction

    task automatic value_err(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        o_val_errs++;
    endtask

    task automatic proto_err(input string what);
        $display("Failure in %s: %s at cycle %0d", test_name, what, cyc);
        o_proto_errs++;
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            if (i_tx_ready || i_pad_vld || i_rx_valid || i_rdatavld) begin
                proto_err("an output is high during reset");
            end
            ctrl = 2'b00;
            words = 0;
            errs = 0;
            hi_state = 1'b0;
            p_vld = 1'b0;
            exp_vld = 1'b0;
            rd_pend = 1'b0;
            prev_acc = 1'b0;
        end else begin
            cyc++;
            // --------------------------------------------------
            // Responses due at this edge
            if (rd_pend) begin
                if (!i_rdatavld) proto_err("read data valid did not come");
                else if (i_rdata !== rd_exp) value_err("read data", rd_exp, i_rdata);
            end else if (i_rdatavld) begin
                proto_err("read data valid without a read");
            end
            if (exp_vld) begin
                if (!i_rx_valid) proto_err("a word was expected but rx valid stayed low");
                else if (i_rx_data !== exp_data) value_err("rx data", exp_data, i_rx_data);
            end else if (i_rx_valid) begin
                proto_err("rx valid pulsed with no word expected");
            end
            exp_vld = 1'b0;
            // Read captures register values from before this edge
            rd_pend = i_read;
            if (i_read) begin
                case (i_addr)
                    `AIB_REG_CTRL:  rd_exp = {30'd0, ctrl};
                    `AIB_REG_WORDS: rd_exp = words;
                    `AIB_REG_ERRS:  rd_exp = errs;
                    default:        rd_exp = '0;
                endcase
            end
            // --------------------------------------------------
            // Transmit handshake
            if (prev_acc && i_tx_ready) proto_err("tx ready high in the cycle after an accept");
            if (!ctrl[0] && i_tx_ready) proto_err("tx ready high while transmit disabled");
            prev_acc = i_tx_valid && i_tx_ready;
            if (prev_acc) begin
                acc_q.push_back(i_tx_data);
                acc_cyc.push_back(cyc);
            end
            // --------------------------------------------------
            // Receive model on the registered beat
            if (p_vld && p_txmark) begin
                if (acc_q.size() == 0) begin
                    proto_err("pad beat sent without an accepted word");
                end else begin
                    cur_word = acc_q.pop_front();
                    cur_cyc  = acc_cyc.pop_front();
                end
            end
            // Low beat of an accepted word is due two edges after its accept
            if (acc_cyc.size() != 0 && cyc >= acc_cyc[0] + 2) begin
                proto_err("an accepted word never reached the pads");
                void'(acc_q.pop_front());
                void'(acc_cyc.pop_front());
            end
            if (!ctrl[1]) begin
                hi_state = 1'b0;
            end else if (p_vld) begin
                r = frame_beat(hi_state, p_mark);
                if (r[1]) errs++;
                if (r[0]) begin
                    words++;
                    exp_vld  = 1'b1;
                    exp_data = {p_beat, lo};
                    if (exp_data !== cur_word) value_err("loopback word", cur_word, exp_data);
                    if (cyc != cur_cyc + 3) proto_err("word arrived with wrong latency");
                end
                if (p_mark) lo = p_beat;
                hi_state = r[2];
            end
            p_vld    = i_pad_vld;
            p_mark   = i_pad_rx_mark;
            p_txmark = i_pad_tx_mark;
            p_beat   = i_pad_beat;
            // Register writes take effect after this edge
            if (i_write && i_addr == `AIB_REG_CTRL) ctrl = i_wdata[1:0];
            if (i_write && i_addr == `AIB_REG_WORDS) begin
                words = 0;
                errs  = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_aib_chan.sv */
// Testbench top of the AIB channel, runs the DUT in pad loopback and drives all test phases
`default_nettype none

`include "aib_consts.svh"

module tb_aib_chan
    import aib_pkg::*;
();

    localparam int N_WORDS = 200 + 4 + 20;          // Words sent over all tests
    localparam int LIMIT   = 8 * N_WORDS + 400;

    logic          clk = 1'b0;
    logic          rst_n;
    aib_cfg_addr_t addr;
    logic          rd;
    logic          wr;
    aib_cfg_data_t wdata;
    aib_cfg_data_t rdata;
    logic          rdatavld;
    aib_word_t     tx_data;
    logic          tx_valid;
    logic          tx_ready;
    aib_word_t     rx_data;
    logic          rx_valid;
    aib_beat_t     pad_beat;
    logic          pad_vld;
    logic          pad_mark;
    wire logic     rx_mark;
    logic          corrupt;
    int            seed = 92567;
    int            cycles = 0;
    int            val_errs;
    int            proto_errs;

    always #2 clk = ~clk;

    // Pad loopback, corrupt drops the next mark
    assign rx_mark = pad_mark & ~corrupt;

    aib_chan_top uut (
        .i_tx_pma_clk(clk), .i_rst_n(rst_n),
        .i_cfg_avmm_addr(addr), .i_cfg_avmm_read(rd), .i_cfg_avmm_write(wr),
        .i_cfg_avmm_wdata(wdata), .o_cfg_avmm_rdata(rdata), .o_cfg_avmm_rdatavld(rdatavld),
        .i_tx_data(tx_data), .i_tx_valid(tx_valid), .o_tx_ready(tx_ready),
        .o_rx_data(rx_data), .o_rx_valid(rx_valid),
        .o_iopad_tx(pad_beat), .o_iopad_tx_vld(pad_vld), .o_iopad_tx_mark(pad_mark),
        .i_iopad_rx(pad_beat), .i_iopad_rx_vld(pad_vld), .i_iopad_rx_mark(rx_mark)
    );

    aib_chan_checker chk (
        .i_clk(clk), .i_rst_n(rst_n), .i_addr(addr), .i_read(rd), .i_write(wr),
        .i_wdata(wdata), .i_rdata(rdata), .i_rdatavld(rdatavld),
        .i_tx_data(tx_data), .i_tx_valid(tx_valid), .i_tx_ready(tx_ready),
        .i_rx_data(rx_data), .i_rx_valid(rx_valid), .i_pad_beat(pad_beat),
        .i_pad_vld(pad_vld), .i_pad_tx_mark(pad_mark), .i_pad_rx_mark(rx_mark),
        .o_val_errs(val_errs), .o_proto_errs(proto_errs)
    );

    always @(posedge clk) begin
        if (corrupt && pad_mark) corrupt <= 1'b0;
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run stopped, cycle limit of %0d reached", LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Bus and stream tasks
    function automatic aib_word_t rand_word();
        logic [63:0] bits;
        bits = {$random(seed), $random(seed)};
        return bits[`AIB_WORD_W-1:0];
    endfunction

    task automatic cfg_write(input aib_cfg_addr_t a, input aib_cfg_data_t d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic cfg_read(input aib_cfg_addr_t a);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(posedge clk);
        rd   <= 1'b0;
        @(posedge clk);                             // Data returns here
    endtask

    task automatic send_word(input aib_word_t w, input logic bad);
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        tx_data  <= w;
        tx_valid <= 1'b1;
        @(posedge clk);
        while (!tx_ready) @(posedge clk);
        tx_valid <= 1'b0;
        corrupt  <= bad;                            // Low beat leaves now
    endtask

    task automatic read_all();
        cfg_read(`AIB_REG_CTRL);
        cfg_read(`AIB_REG_WORDS);
        cfg_read(`AIB_REG_ERRS);
    endtask

    initial begin
        rst_n = 1'b0;
        addr = '0;
        rd = 1'b0;
        wr = 1'b0;
        wdata = '0;
        tx_data = '0;
        tx_valid = 1'b0;
        corrupt = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        chk.test_name = "reset";
        read_all();

        chk.test_name = "registers";
        repeat (4) begin
            cfg_write(`AIB_REG_CTRL, $random(seed));
            cfg_read(`AIB_REG_CTRL);
        end

        chk.test_name = "loopback";
        cfg_write(`AIB_REG_CTRL, 32'h3);
        for (int i = 0; i < 200; i++) send_word(rand_word(), 1'b0);
        repeat (8) @(posedge clk);
        read_all();

        chk.test_name = "tx_disable";
        cfg_write(`AIB_REG_CTRL, 32'h2);
        @(posedge clk);
        tx_data  <= rand_word();
        tx_valid <= 1'b1;
        repeat (12) @(posedge clk);
        tx_valid <= 1'b0;

        chk.test_name = "rx_disable";
        cfg_write(`AIB_REG_CTRL, 32'h1);
        for (int i = 0; i < 4; i++) send_word(rand_word(), 1'b0);
        repeat (8) @(posedge clk);
        read_all();

        chk.test_name = "framing";
        cfg_write(`AIB_REG_CTRL, 32'h3);
        cfg_write(`AIB_REG_WORDS, 32'h0);
        for (int i = 0; i < 20; i++) begin
            send_word(rand_word(), i == 3 || i == 7 || i == 8 || i == 15);
        end
        repeat (8) @(posedge clk);
        read_all();
        cfg_write(`AIB_REG_WORDS, 32'h0);
        read_all();

        repeat (4) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* aib_chan_top.f */
+incdir+include
logic/aib_pkg.sv
logic/aib_rx_ctrl_if.sv
logic/aib_cfg_avmm.sv
logic/aib_tx_adapt.sv
logic/aib_rx_adapt.sv
logic/aib_chan_top.sv
tb/aib_chan_checker.sv
tb/tb_aib_chan.sv
